// File: common/ita_ctrl_pkg.sv
/*
 * sizes, layer/step encodings and the shared structs
 * of the tiling controller
 */

`default_nettype none

package ita_ctrl_pkg;

  localparam int N          = 4;   // lanes per beat
  localparam int M          = 8;   // tile edge
  localparam int BEATS      = M * M / N;
  localparam int FIFO_DEPTH = 2;   // output buffer, in tiles
  localparam int CW         = 8;
  localparam int DW         = 10;
  localparam int BW         = 24;

  localparam int MB    = $clog2(M);
  localparam int NB    = $clog2(N);
  localparam int OCC_W = $clog2(FIFO_DEPTH + 1);
  localparam int POS_W = CW + MB + 1;  // row/col position in elements

  typedef enum logic [1:0] {
    Linear,
    Feedforward
  } layer_e;

  typedef enum logic [1:0] {
    Idle,
    MatMul,
    F1,
    F2
  } step_e;

  typedef logic [CW-1:0] counter_t;
  typedef logic [DW-1:0] dim_t;

  typedef struct packed {
    logic     start;
    layer_e   layer;
    counter_t tile_s;  // row tiles
    counter_t tile_e;
    counter_t tile_f;
    counter_t tile_p;
    dim_t     seq_length;
    dim_t     embed_size;
    dim_t     ff_size;
    dim_t     proj_space;
  } ctrl_t;

  typedef logic [N-1:0][BW-1:0] bias_t;
  typedef logic [N-1:0]         lane_mask_t;

  // one issued beat
  typedef struct packed {
    counter_t beat;
    counter_t inner;
    counter_t tile_x;
    counter_t tile_y;
    step_e    step;
    logic     last_inner;
  } tile_pos_t;

endpackage

`default_nettype wire

// File: hw/ita_bias_pad.sv
/*
 * edge padding of bias and requant-add lanes in F1/F2
 */

`timescale 1ns/1ns
`default_nettype none

module ita_bias_pad (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ita_ctrl_pkg::ctrl_t      ctrl_i,
  input  logic                     calc_en_i,
  input  ita_ctrl_pkg::tile_pos_t  pos_i,
  input  ita_ctrl_pkg::bias_t      bias_i,
  input  logic                     requant_add_i,
  output ita_ctrl_pkg::bias_t      bias_pad_o,
  output ita_ctrl_pkg::lane_mask_t requant_add_o,
  output logic                     pad_valid_o
);

  import ita_ctrl_pkg::*;

  logic [POS_W-1:0] row;
  logic [POS_W-1:0] col_base;
  dim_t             cols;
  lane_mask_t       keep;
  bias_t            bias_d, bias_q;
  lane_mask_t       mask_d, mask_q;
  logic             valid_q;

  always_comb begin
    case (pos_i.step)
      F1:      cols = ctrl_i.ff_size;
      F2:      cols = ctrl_i.embed_size;
      default: cols = ctrl_i.proj_space;
    endcase
  end

  // beat walks M rows, then steps N columns to the right
  assign row      = POS_W'(pos_i.beat[MB-1:0]) + (POS_W'(pos_i.tile_y) << MB);
  assign col_base = (POS_W'(pos_i.beat >> MB) << NB) + (POS_W'(pos_i.tile_x) << MB);

  always_comb begin
    keep = '1;
    if ((pos_i.step == F1) || (pos_i.step == F2)) begin
      for (int i = 0; i < N; i++) begin
        keep[i] = (row < POS_W'(ctrl_i.seq_length)) &&
                  ((col_base + POS_W'(i)) < POS_W'(cols));
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      bias_d[i] = keep[i] ? bias_i[i] : '0;
      mask_d[i] = keep[i] & requant_add_i;  // broadcast bit
    end
  end

  always_ff @(posedge clk_i) begin
    if (calc_en_i) begin
      bias_q <= bias_d;
      mask_q <= mask_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= calc_en_i;
    end
  end

  assign bias_pad_o    = bias_q;
  assign requant_add_o = mask_q;
  assign pad_valid_o   = valid_q;

endmodule

`default_nettype wire

// File: hw/ita_ctrl_top.sv
/*
 * tiling controller top: issue gate, step sequencer, bias padding
 */

`timescale 1ns/1ns
`default_nettype none

module ita_ctrl_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ita_ctrl_pkg::ctrl_t      ctrl_i,
  input  logic                     inp_valid_i,
  output logic                     inp_ready_o,
  input  logic                     weight_valid_i,
  output logic                     weight_ready_o,
  input  logic                     bias_valid_i,
  output logic                     bias_ready_o,
  input  logic                     oup_valid_i,
  input  logic                     oup_ready_i,
  input  ita_ctrl_pkg::bias_t      bias_i,
  input  logic                     requant_add_i,
  output logic                     calc_en_o,
  output ita_ctrl_pkg::step_e      step_o,
  output logic                     busy_o,
  output ita_ctrl_pkg::tile_pos_t  pos_o,
  output logic                     first_inner_tile_o,
  output ita_ctrl_pkg::bias_t      bias_pad_o,
  output ita_ctrl_pkg::lane_mask_t requant_add_o,
  output logic                     pad_valid_o
);

  import ita_ctrl_pkg::*;

  step_e     step;
  tile_pos_t pos;
  logic      calc_en;

  ita_issue_gate ita_issue_gate_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .step_i         (step),
    .pos_i          (pos),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .calc_en_o      (calc_en)
  );

  ita_step_sequencer ita_step_sequencer_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .ctrl_i             (ctrl_i),
    .calc_en_i          (calc_en),
    .step_o             (step),
    .busy_o             (busy_o),
    .pos_o              (pos),
    .first_inner_tile_o (first_inner_tile_o)
  );

  ita_bias_pad ita_bias_pad_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_i),
    .calc_en_i     (calc_en),
    .pos_i         (pos),
    .bias_i        (bias_i),
    .requant_add_i (requant_add_i),
    .bias_pad_o    (bias_pad_o),
    .requant_add_o (requant_add_o),
    .pad_valid_o   (pad_valid_o)
  );

  assign calc_en_o = calc_en;
  assign step_o    = step;
  assign pos_o     = pos;

endmodule

`default_nettype wire

// File: hw/ita_issue_gate.sv
/*
 * issue gate: cross-coupled readies, calc enable
 * and output buffer occupancy
 */

`timescale 1ns/1ns
`default_nettype none

module ita_issue_gate (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  inp_valid_i,
  input  logic                  weight_valid_i,
  input  logic                  bias_valid_i,
  input  logic                  oup_valid_i,
  input  logic                  oup_ready_i,
  input  ita_ctrl_pkg::step_e     step_i,
  input  ita_ctrl_pkg::tile_pos_t pos_i,
  output logic                  inp_ready_o,
  output logic                  weight_ready_o,
  output logic                  bias_ready_o,
  output logic                  calc_en_o
);

  import ita_ctrl_pkg::*;

  logic [OCC_W-1:0] occ_q;
  logic             open_issue;
  logic             tile_done;
  logic             tile_taken;

  assign open_issue = (step_i != Idle) && (occ_q < OCC_W'(FIFO_DEPTH));

  always_comb begin
    inp_ready_o    = 1'b0;
    weight_ready_o = 1'b0;
    bias_ready_o   = 1'b0;
    if (open_issue) begin
      inp_ready_o    = weight_valid_i;
      weight_ready_o = inp_valid_i;
      bias_ready_o   = weight_valid_i;
    end
  end

  assign calc_en_o = open_issue && inp_valid_i && weight_valid_i && bias_valid_i;

  // last beat of the last inner tile completes an output tile
  assign tile_done  = calc_en_o && pos_i.last_inner && (pos_i.beat == counter_t'(BEATS - 1));
  assign tile_taken = oup_valid_i && oup_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else if (tile_done && !tile_taken) begin
      occ_q <= occ_q + 1'b1;
    end else if (tile_taken && !tile_done && (occ_q != '0)) begin
      occ_q <= occ_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/sequencer/ita_step_sequencer.sv
/*
 * step FSM with beat, inner tile and tile_x/tile_y counters
 */

`timescale 1ns/1ns
`default_nettype none

module ita_step_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  ita_ctrl_pkg::ctrl_t     ctrl_i,
  input  logic                    calc_en_i,
  output ita_ctrl_pkg::step_e     step_o,
  output logic                    busy_o,
  output ita_ctrl_pkg::tile_pos_t pos_o,
  output logic                    first_inner_tile_o
);

  import ita_ctrl_pkg::*;

  step_e    step_d, step_q;
  logic     busy_d, busy_q;
  counter_t beat_d, beat_q;
  counter_t inner_d, inner_q;
  counter_t tile_x_d, tile_x_q;
  counter_t tile_y_d, tile_y_q;
  counter_t inner_dim;
  counter_t x_lim;
  logic     last_inner;

  // inner and x extents per step
  always_comb begin
    case (step_q)
      MatMul: begin
        inner_dim = ctrl_i.tile_e;
        x_lim     = ctrl_i.tile_p;
      end
      F1: begin
        inner_dim = ctrl_i.tile_e;
        x_lim     = ctrl_i.tile_f;
      end
      F2: begin
        inner_dim = ctrl_i.tile_f;
        x_lim     = ctrl_i.tile_e;
      end
      default: begin
        inner_dim = '0;
        x_lim     = '0;
      end
    endcase
  end

  assign last_inner = (step_q != Idle) && (inner_q == counter_t'(inner_dim - 1'b1));

  always_comb begin
    step_d   = step_q;
    beat_d   = beat_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;

    if (step_q == Idle) begin
      beat_d   = '0;
      inner_d  = '0;
      tile_x_d = '0;
      tile_y_d = '0;
      if (ctrl_i.start) begin
        step_d = (ctrl_i.layer == Feedforward) ? F1 : MatMul;
      end
    end else if (calc_en_i) begin
      beat_d = beat_q + 1'b1;
      if (beat_q == counter_t'(BEATS - 1)) begin  // end of tile
        beat_d  = '0;
        inner_d = inner_q + 1'b1;
        if (inner_d == inner_dim) begin
          inner_d  = '0;
          tile_x_d = tile_x_q + 1'b1;
          if (tile_x_d == x_lim) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
            if (tile_y_d == ctrl_i.tile_s) begin  // step done
              tile_y_d = '0;
              step_d   = (step_q == F1) ? F2 : Idle;
            end
          end
        end
      end
    end

    busy_d = (step_d != Idle);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= Idle;
      busy_q   <= 1'b0;
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
    end else begin
      step_q   <= step_d;
      busy_q   <= busy_d;
      beat_q   <= beat_d;
      inner_q  <= inner_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
    end
  end

  assign step_o             = step_q;
  assign busy_o             = busy_q;
  assign first_inner_tile_o = (inner_q == '0);

  always_comb begin
    pos_o.beat       = beat_q;
    pos_o.inner      = inner_q;
    pos_o.tile_x     = tile_x_q;
    pos_o.tile_y     = tile_y_q;
    pos_o.step       = step_q;
    pos_o.last_inner = last_inner;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+test
common/ita_ctrl_pkg.sv
hw/ita_issue_gate.sv
hw/sequencer/ita_step_sequencer.sv
hw/ita_bias_pad.sv
hw/ita_ctrl_top.sv
test/ita_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tiling controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f project.f --top-module ita_ctrl_tb \
  -Mdir obj_dir -o ita_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ita_ctrl_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
exit 0

// File: test/ita_ctrl_model.svh
/*
 * reference model of the tile walk, occupancy state
 * and the F1/F2 edge padding rule
 */

`ifndef ITA_CTRL_MODEL_SVH
`define ITA_CTRL_MODEL_SVH

ctrl_t m_cfg;
step_e m_step = Idle;
int    m_beat = 0;
int    m_inner = 0;
int    m_x = 0;
int    m_y = 0;
int    m_occ = 0;  // finished tiles not yet taken

function automatic int inner_of(step_e s, ctrl_t c);
  return (s == F2) ? int'(c.tile_f) : int'(c.tile_e);
endfunction

function automatic int xlim_of(step_e s, ctrl_t c);
  case (s)
    F1:      return int'(c.tile_f);
    F2:      return int'(c.tile_e);
    default: return int'(c.tile_p);
  endcase
endfunction

function automatic int cols_of(step_e s, ctrl_t c);
  case (s)
    F1:      return int'(c.ff_size);
    F2:      return int'(c.embed_size);
    default: return int'(c.proj_space);
  endcase
endfunction

function automatic int step_beats(step_e s, ctrl_t c);
  return int'(c.tile_s) * xlim_of(s, c) * inner_of(s, c) * BEATS;
endfunction

function automatic int layer_beats(ctrl_t c);
  if (c.layer == Feedforward) begin
    return step_beats(F1, c) + step_beats(F2, c);
  end
  return step_beats(MatMul, c);
endfunction

function automatic void model_start(ctrl_t c);
  m_cfg   = c;
  m_step  = (c.layer == Feedforward) ? F1 : MatMul;
  m_beat  = 0;
  m_inner = 0;
  m_x     = 0;
  m_y     = 0;
endfunction

function automatic tile_pos_t expected_pos();
  tile_pos_t p;
  p.beat       = counter_t'(m_beat);
  p.inner      = counter_t'(m_inner);
  p.tile_x     = counter_t'(m_x);
  p.tile_y     = counter_t'(m_y);
  p.step       = m_step;
  p.last_inner = (m_inner == inner_of(m_step, m_cfg) - 1);
  return p;
endfunction

// one issued beat moves the walk forward
function automatic void model_advance();
  m_beat++;
  if (m_beat == BEATS) begin
    m_beat = 0;
    m_inner++;
    if (m_inner == inner_of(m_step, m_cfg)) begin
      m_inner = 0;
      m_x++;
      if (m_x == xlim_of(m_step, m_cfg)) begin
        m_x = 0;
        m_y++;
        if (m_y == int'(m_cfg.tile_s)) begin
          m_y    = 0;
          m_step = (m_step == F1) ? F2 : Idle;
        end
      end
    end
  end
endfunction

function automatic bit lane_kept(tile_pos_t p, ctrl_t c, int i);
  int row;
  int col;
  row = int'(p.beat) % M + int'(p.tile_y) * M;
  col = (int'(p.beat) / M) * N + int'(p.tile_x) * M + i;
  if ((p.step != F1) && (p.step != F2)) begin
    return 1'b1;
  end
  return (row < int'(c.seq_length)) && (col < cols_of(p.step, c));
endfunction

function automatic bias_t pad_bias(tile_pos_t p, ctrl_t c, bias_t b);
  bias_t r;
  for (int i = 0; i < N; i++) begin
    r[i] = lane_kept(p, c, i) ? b[i] : '0;
  end
  return r;
endfunction

function automatic lane_mask_t pad_mask(tile_pos_t p, ctrl_t c, logic rq);
  lane_mask_t r;
  for (int i = 0; i < N; i++) begin
    r[i] = lane_kept(p, c, i) && rq;
  end
  return r;
endfunction

`endif

// File: test/ita_ctrl_tb.sv
/*
 * testbench of the tiling controller with random valids, model walk,
 * readies, padding and back-pressure checks
 */

`timescale 1ns/1ns
`default_nettype none

module ita_ctrl_tb;

  import ita_ctrl_pkg::*;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  ctrl_t      ctrl_i;
  logic       inp_valid_i, inp_ready_o;
  logic       weight_valid_i, weight_ready_o;
  logic       bias_valid_i, bias_ready_o;
  logic       oup_valid_i, oup_ready_i;
  bias_t      bias_i, bias_pad_o, exp_bias;
  logic       requant_add_i;
  logic       calc_en_o, busy_o, first_inner_tile_o, pad_valid_o;
  step_e      step_o, last_step;
  tile_pos_t  pos_o, pexp;
  lane_mask_t requant_add_o, exp_mask;

  integer seed = 39533;
  int     cycles = 0;
  int     limit;
  int     beat_cnt [4];
  step_e  seen [$];
  logic   stim_en, bp_hold, pad_pend, open_exp, tile_done;
  ctrl_t  cfg_lin, cfg_ff, cfg_bp;

  `include "ita_ctrl_model.svh"

  ita_ctrl_top ita_ctrl_top_inst (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run not finished within %0d cycles", limit);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string name, input logic [95:0] got,
                                 input logic [95:0] exp);
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_pos(input string name, input tile_pos_t got, input tile_pos_t exp);
    if (got !== exp) report_mismatch(name, 96'(got), 96'(exp));
  endtask

  task automatic check_step(input string name, input step_e got, input step_e exp);
    if (got !== exp) report_mismatch(name, 96'(got), 96'(exp));
  endtask

  task automatic check_bias(input string name, input bias_t got, input bias_t exp);
    if (got !== exp) report_mismatch(name, 96'(got), 96'(exp));
  endtask

  task automatic check_mask(input string name, input lane_mask_t got, input lane_mask_t exp);
    if (got !== exp) report_mismatch(name, 96'(got), 96'(exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, 96'(got), 96'(exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) report_mismatch(name, 96'(got), 96'(exp));
  endtask

  // dimension with a partial last tile most of the time
  function automatic dim_t edge_dim(counter_t t);
    return dim_t'((int'(t) - 1) * M + 1 + {$random(seed)} % M);
  endfunction

  function automatic ctrl_t draw_cfg(layer_e layer, int lo);
    ctrl_t c;
    c            = '0;
    c.layer      = layer;
    c.tile_s     = counter_t'(lo + {$random(seed)} % (4 - lo));
    c.tile_e     = counter_t'(lo + {$random(seed)} % (4 - lo));
    c.tile_f     = counter_t'(lo + {$random(seed)} % (4 - lo));
    c.tile_p     = counter_t'(lo + {$random(seed)} % (4 - lo));
    c.seq_length = edge_dim(c.tile_s);
    c.embed_size = edge_dim(c.tile_e);
    c.ff_size    = edge_dim(c.tile_f);
    c.proj_space = edge_dim(c.tile_p);
    return c;
  endfunction

  always @(posedge clk_i) begin
    #2;
    inp_valid_i    = stim_en && ({$random(seed)} % 8 != 0);
    weight_valid_i = stim_en && ({$random(seed)} % 8 != 0);
    bias_valid_i   = stim_en && ({$random(seed)} % 8 != 0);
    requant_add_i  = 1'($random(seed));
    for (int i = 0; i < N; i++) begin
      bias_i[i] = BW'($random(seed));
    end
    oup_valid_i = (m_occ != 0) && ({$random(seed)} % 4 != 0);  // only when a tile waits
    oup_ready_i = !bp_hold;
  end

  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_bit("pad_valid_o", pad_valid_o, pad_pend);
      if (pad_pend) begin
        check_bias("bias_pad_o", bias_pad_o, exp_bias);
        check_mask("requant_add_o", requant_add_o, exp_mask);
      end
      check_step("step_o", step_o, m_step);
      check_bit("busy_o", busy_o, m_step != Idle);
      check_bit("first_inner_tile_o", first_inner_tile_o, m_inner == 0);
      open_exp = (m_step != Idle) && (m_occ < FIFO_DEPTH);
      check_bit("inp_ready_o", inp_ready_o, open_exp && weight_valid_i);
      check_bit("weight_ready_o", weight_ready_o, open_exp && inp_valid_i);
      check_bit("bias_ready_o", bias_ready_o, open_exp && weight_valid_i);
      check_bit("calc_en_o", calc_en_o,
                open_exp && inp_valid_i && weight_valid_i && bias_valid_i);
      if (step_o != last_step) begin
        seen.push_back(step_o);
        last_step = step_o;
      end
      pad_pend  = calc_en_o;
      tile_done = 1'b0;
      if (m_step == Idle) begin
        if (ctrl_i.start) model_start(ctrl_i);
      end else if (calc_en_o) begin
        pexp = expected_pos();
        check_pos("pos_o", pos_o, pexp);
        exp_bias = pad_bias(pexp, m_cfg, bias_i);
        exp_mask = pad_mask(pexp, m_cfg, requant_add_i);
        beat_cnt[int'(m_step)]++;
        tile_done = pexp.last_inner && (int'(pexp.beat) == BEATS - 1);
        model_advance();
      end
      if (tile_done && !(oup_valid_i && oup_ready_i)) begin
        m_occ++;
      end else if (!tile_done && oup_valid_i && oup_ready_i) begin
        m_occ--;
      end
    end
  end

  task automatic run_layer(input ctrl_t cfg, input logic stall);
    int stalled;
    stalled = 0;
    for (int s = 0; s < 4; s++) begin
      beat_cnt[s] = 0;
    end
    seen.delete();
    bp_hold = stall;
    @(posedge clk_i);
    #2;
    ctrl_i       = cfg;
    ctrl_i.start = 1'b1;
    @(posedge clk_i);
    #2;
    ctrl_i.start = 1'b0;
    if (stall) begin
      do @(posedge clk_i); while (m_occ < FIFO_DEPTH);
      repeat (20) begin
        @(negedge clk_i);
        stalled += int'(calc_en_o);
      end
      check_count("beats issued with full buffer", stalled, 0);
      bp_hold = 1'b0;  // drain so issue resumes
    end
    do @(negedge clk_i); while (busy_o);
    @(posedge clk_i);
    if (cfg.layer == Feedforward) begin
      check_count("F1 beats", beat_cnt[int'(F1)], step_beats(F1, cfg));
      check_count("F2 beats", beat_cnt[int'(F2)], step_beats(F2, cfg));
      check_count("step changes", seen.size(), 3);
      check_step("first step", seen[0], F1);
      check_step("second step", seen[1], F2);
      check_step("final step", seen[2], Idle);
    end else begin
      check_count("MatMul beats", beat_cnt[int'(MatMul)], step_beats(MatMul, cfg));
      check_count("step changes", seen.size(), 2);
      check_step("first step", seen[0], MatMul);
      check_step("final step", seen[1], Idle);
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    ctrl_i         = '0;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
    oup_valid_i    = 1'b0;
    oup_ready_i    = 1'b1;
    bias_i         = '0;
    requant_add_i  = 1'b0;
    stim_en        = 1'b0;
    bp_hold        = 1'b0;
    pad_pend       = 1'b0;
    last_step      = Idle;
    cfg_lin        = draw_cfg(Linear, 1);
    cfg_ff         = draw_cfg(Feedforward, 1);
    cfg_bp         = draw_cfg(Linear, 2);  // at least 4 output tiles
    limit = 4 * (layer_beats(cfg_lin) + layer_beats(cfg_ff) + layer_beats(cfg_bp)) + 200;

    @(posedge clk_i);
    @(negedge clk_i);
    check_bit("calc_en_o", calc_en_o, 1'b0);
    check_bit("inp_ready_o", inp_ready_o, 1'b0);
    check_bit("weight_ready_o", weight_ready_o, 1'b0);
    check_bit("bias_ready_o", bias_ready_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("pad_valid_o", pad_valid_o, 1'b0);
    check_step("step_o", step_o, Idle);
    stim_en = 1'b1;
    @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    run_layer(cfg_lin, 1'b0);
    run_layer(cfg_ff, 1'b0);
    run_layer(cfg_bp, 1'b1);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
